// ==== dv/na_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network adapter testbench
// table driven bus steps, network source and sink, seed model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "na_regs.svh"

module na_tb;
   import na_pkg::*;

   localparam logic [31:0] T_TILE_ID   = 32'd5;
   localparam logic [31:0] T_NUM_TILES = 32'd16;
   localparam logic [31:0] T_CORE_BASE = 32'd20;
   localparam int OP_RD   = 0;   // bus read
   localparam int OP_WR   = 1;   // bus write
   localparam int OP_INJ  = 2;   // inbound flit
   localparam int OP_ORDY = 3;   // out_ready mode, 0 low 1 high 2 random
   localparam int MAX_ROWS = 64;

   logic              clk;
   logic              rst;
   logic              cyc;
   logic              stb;
   logic              we;
   logic [ADR_W-1:0]  adr;
   logic [WORD_W-1:0] wdata;
   logic [WORD_W-1:0] rdata;
   logic              ack;
   logic              err;
   logic [WORD_W-1:0] out_flit;
   logic              out_valid;
   logic              out_ready;
   logic [WORD_W-1:0] in_flit;
   logic              in_valid;
   logic              in_ready;

   logic [1:0]        row_op  [0:MAX_ROWS-1];
   logic [ADR_W-1:0]  row_adr [0:MAX_ROWS-1];
   logic [WORD_W-1:0] row_dat [0:MAX_ROWS-1];
   logic [WORD_W-1:0] row_exp [0:MAX_ROWS-1];
   logic              row_err [0:MAX_ROWS-1];
   int                n_rows = 0;
   int                cycles = 0;
   int                cycle_limit = 1000;   // replaced once the table is built
   int                ordy_mode;
   logic [WORD_W-1:0] sent_q[$];   // accepted send writes
   logic [WORD_W-1:0] got_q[$];    // flits seen leaving

   na_top #(
      .TILE_ID    (T_TILE_ID),
      .NUM_TILES  (T_NUM_TILES),
      .CORE_BASE  (T_CORE_BASE),
      .MP_ENABLE  (1'b1),
      .FIFO_DEPTH (4)
   ) dut (
      .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .we (we), .adr (adr),
      .wdata (wdata), .rdata (rdata), .ack (ack), .err (err),
      .out_flit (out_flit), .out_valid (out_valid), .out_ready (out_ready),
      .in_flit (in_flit), .in_valid (in_valid), .in_ready (in_ready)
   );

   bind na_top na_tb_sva u_sva (
      .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .ack (ack), .err (err),
      .out_valid (out_valid), .out_ready (out_ready), .out_flit (out_flit)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [ADR_W-1:0] conf_adr(input int ofs);
      return ADR_W'(ofs * 4);            // region 0
   endfunction

   function automatic logic [ADR_W-1:0] mp_adr(input int ofs);
      return 16'h1000 | ADR_W'(ofs * 4); // region 1
   endfunction

   // reference seed model, galois right shift with taps
   function automatic logic [WORD_W-1:0] seed_step(input logic [WORD_W-1:0] s);
      return (s >> 1) ^ (s[0] ? SEED_TAPS : '0);
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "run stopped at time %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
      if (exp !== act) begin
         fail_stop($sformatf("error: time %0t signal %s expected %h actual %h",
                             $time, name, exp, act));
      end
   endtask

   task automatic add_row(input int op, input logic [ADR_W-1:0] a,
                          input logic [WORD_W-1:0] d, input logic [WORD_W-1:0] x,
                          input logic e);
      row_op[n_rows]  = op[1:0];
      row_adr[n_rows] = a;
      row_dat[n_rows] = d;
      row_exp[n_rows] = x;
      row_err[n_rows] = e;
      n_rows++;
   endtask

   task automatic build_table();
      logic [WORD_W-1:0] s;
      // tile facts, holes and a read-only write
      add_row(OP_RD, conf_adr(`REG_TILEID), 0, T_TILE_ID, 0);
      add_row(OP_RD, conf_adr(`REG_NUMTILES), 0, T_NUM_TILES, 0);
      add_row(OP_RD, conf_adr(`REG_CONF), 0, 32'h1 << `CONFBIT_MPSIMPLE, 0);
      add_row(OP_RD, conf_adr(`REG_COREBASE), 0, T_CORE_BASE, 0);
      add_row(OP_RD, conf_adr(2), 0, 0, 0);
      add_row(OP_RD, conf_adr(7), 0, 0, 0);
      add_row(OP_WR, conf_adr(`REG_TILEID), 32'hffff_ffff, 0, 0);
      add_row(OP_RD, conf_adr(`REG_TILEID), 0, T_TILE_ID, 0);
      s = SEED_INIT;                                // seed sequence
      repeat (4) begin
         add_row(OP_RD, conf_adr(`REG_SEED), 0, s, 0);
         s = seed_step(s);
      end
      // messaging off, then on
      add_row(OP_WR, mp_adr(`REG_MP_SEND), 32'h11, 0, 1);
      add_row(OP_INJ, 0, 32'h99, 0, 1);             // in_ready low
      add_row(OP_RD, conf_adr(`REG_CTRL), 0, 0, 0);
      add_row(OP_WR, conf_adr(`REG_CTRL), 32'h1 << `CTRLBIT_MP_EN, 0, 0);
      add_row(OP_RD, conf_adr(`REG_CTRL), 0, 1, 0);
      add_row(OP_RD, mp_adr(`REG_MP_STATUS), 0, 0, 0);
      // sends under random back-pressure
      add_row(OP_ORDY, 0, 2, 0, 0);
      for (int i = 0; i < 4; i++) add_row(OP_WR, mp_adr(`REG_MP_SEND), 32'ha0 + i, 0, 0);
      // sends with the network stalled
      add_row(OP_ORDY, 0, 0, 0, 0);
      for (int i = 0; i < 4; i++) add_row(OP_WR, mp_adr(`REG_MP_SEND), 32'hb0 + i, 0, 0);
      add_row(OP_WR, mp_adr(`REG_MP_SEND), 32'hbf, 0, 1);   // queue full
      add_row(OP_RD, mp_adr(`REG_MP_STATUS), 0, 32'h1 << `STATBIT_TX_FULL, 0);
      add_row(OP_ORDY, 0, 1, 0, 0);
      // receive path
      for (int i = 0; i < 4; i++) add_row(OP_INJ, 0, 32'hc0 + i, 0, 0);
      add_row(OP_INJ, 0, 32'hcf, 0, 1);             // receive queue full
      add_row(OP_RD, mp_adr(`REG_MP_STATUS), 0,
              (32'd4 << `STAT_RX_COUNT) | (32'h1 << `STATBIT_RX_AVAIL), 0);
      for (int i = 0; i < 4; i++) add_row(OP_RD, mp_adr(`REG_MP_RECV), 0, 32'hc0 + i, 0);
      add_row(OP_RD, mp_adr(`REG_MP_STATUS), 0, 0, 0);
      add_row(OP_RD, mp_adr(`REG_MP_RECV), 0, 0, 1);   // empty
      add_row(OP_RD, mp_adr(3), 0, 0, 1);              // hole in message region
      // unmapped regions
      add_row(OP_RD, 16'h2000, 0, 0, 1);
      add_row(OP_RD, 16'h3004, 0, 0, 1);
      add_row(OP_WR, 16'h4000, 32'h5, 0, 1);
      add_row(OP_RD, 16'h8004, 0, 0, 1);
      add_row(OP_RD, 16'hf000, 0, 0, 1);
   endtask

   // classic single access, held until ack or err
   task automatic bus_access(input logic wr, input logic [ADR_W-1:0] a,
                             input logic [WORD_W-1:0] d, output logic [WORD_W-1:0] rd,
                             output logic e);
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = a;
      wdata = d;
      @(negedge clk);
      while (!(ack || err)) @(negedge clk);
      rd  = rdata;
      e   = err;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   // one cycle of in_valid, taken only if in_ready is up
   task automatic inject_flit(input logic [WORD_W-1:0] d, input logic refused);
      @(negedge clk);
      in_flit  = d;
      in_valid = 1'b1;
      check_value("in_ready", {31'b0, !refused}, {31'b0, in_ready});
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (got_q.size() != sent_q.size()) @(negedge clk);
   endtask

   // network sink, ready then sample, transfer lands on the next posedge
   initial begin
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         case (ordy_mode)
            0:       out_ready = 1'b0;
            1:       out_ready = 1'b1;
            default: out_ready = $urandom % 2;
         endcase
         if (!rst && out_valid && out_ready) got_q.push_back(out_flit);
      end
   end

   initial begin
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > cycle_limit) begin
            fail_stop($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
         end
      end
   end

   initial begin
      logic [WORD_W-1:0] rd_val;
      logic              e;
      int                seed_val;
      seed_val  = $urandom(58258);
      rst       = 1'b1;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      wdata     = '0;
      in_flit   = '0;
      in_valid  = 1'b0;
      ordy_mode = 2;
      build_table();
      cycle_limit = 20 * n_rows + 100;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         case (row_op[i])
            OP_RD: begin
               bus_access(1'b0, row_adr[i], row_dat[i], rd_val, e);
               check_value("err", {31'b0, row_err[i]}, {31'b0, e});
               if (!e) check_value("rdata", row_exp[i], rd_val);
            end
            OP_WR: begin
               bus_access(1'b1, row_adr[i], row_dat[i], rd_val, e);
               check_value("err", {31'b0, row_err[i]}, {31'b0, e});
               if (!e && row_adr[i] == mp_adr(`REG_MP_SEND)) sent_q.push_back(row_dat[i]);
            end
            OP_INJ: inject_flit(row_dat[i], row_err[i]);
            default: begin
               if (row_dat[i] == 0) wait_drain();   // start stall with an empty queue
               ordy_mode <= int'(row_dat[i]);
            end
         endcase
      end
      wait_drain();
      for (int i = 0; i < sent_q.size(); i++) check_value("out_flit", sent_q[i], got_q[i]);
      if (dut.u_sva.fail_count == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         fail_stop("bound assertions failed during the run");
      end
   end

endmodule

`default_nettype wire

// ==== dv/na_tb_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network adapter assertions
// bus response and outbound handshake rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module na_tb_sva (
   input wire logic                        clk,
   input wire logic                        rst,
   input wire logic                        cyc,
   input wire logic                        stb,
   input wire logic                        ack,
   input wire logic                        err,
   input wire logic                        out_valid,
   input wire logic                        out_ready,
   input wire logic [na_pkg::WORD_W-1:0]   out_flit
);

   int fail_count = 0;   // assertion failures so far

   // one response kind at a time
   a_ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack && err))
      else begin
         fail_count++;
         $error("ack and err high in the same cycle");
      end

   // response only right after an outstanding request
   a_resp_after_req: assert property (@(posedge clk) disable iff (rst)
      (ack || err) |-> $past(cyc && stb && !(ack || err)))
      else begin
         fail_count++;
         $error("response without a request in the previous cycle");
      end

   // accepted request is answered next cycle
   a_req_answered: assert property (@(posedge clk) disable iff (rst)
      (cyc && stb && !(ack || err)) |=> (ack || err))
      else begin
         fail_count++;
         $error("request not answered one cycle later");
      end

   // outbound flit held while stalled
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_flit)))
      else begin
         fail_count++;
         $error("outbound flit dropped or changed before transfer");
      end

endmodule

`default_nettype wire

// ==== include/na_regs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network adapter register map
// word offsets per region and bit positions in the config words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NA_REGS_SVH
`define NA_REGS_SVH

// configuration region, word offsets
`define REG_TILEID        0   // tile id, ro
`define REG_NUMTILES      1   // number of tiles, ro
`define REG_CONF          3   // feature bits, ro
`define REG_COREBASE      4   // core base id, ro
`define REG_CTRL          5   // control, rw
`define REG_SEED          6   // seed, advances per read

// message region, word offsets
`define REG_MP_SEND       0   // write pushes a flit
`define REG_MP_RECV       1   // read pops a flit
`define REG_MP_STATUS     2   // queue state

// bit positions
`define CONFBIT_MPSIMPLE  0
`define CONFBIT_DMA       1   // no dma here, reads 0
`define CTRLBIT_MP_EN     0
`define STATBIT_RX_AVAIL  0
`define STATBIT_TX_FULL   1
`define STAT_RX_COUNT     8   // lsb of receive count field

`endif

// ==== rtl/na_conf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile configuration registers
// read-only tile facts, control register, advancing seed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "na_regs.svh"

module na_conf #(
   parameter logic [31:0] TILE_ID   = 32'd0,
   parameter logic [31:0] NUM_TILES = 32'd1,
   parameter logic [31:0] CORE_BASE = 32'd0,
   parameter bit          MP_ENABLE = 1'b1
) (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        conf_rd,
   input  wire logic                        conf_wr,
   input  wire logic [na_pkg::OFS_W-1:0]    offset,
   input  wire logic [na_pkg::WORD_W-1:0]   reg_wdata,
   output logic      [na_pkg::WORD_W-1:0]   conf_rdata,
   output logic                             mp_en
);
   import na_pkg::*;

   logic [WORD_W-1:0] features;    // feature word
   logic [WORD_W-1:0] ctrl_word;   // control as read back
   logic [WORD_W-1:0] seed;
   logic [WORD_W-1:0] seed_next;
   logic              ctrl_wr;
   logic              seed_rd;

   assign ctrl_wr = conf_wr & (offset == OFS_W'(`REG_CTRL));
   assign seed_rd = conf_rd & (offset == OFS_W'(`REG_SEED));

   // one galois step, right shift
   assign seed_next = {1'b0, seed[WORD_W-1:1]} ^ (seed[0] ? SEED_TAPS : '0);

   always_comb begin
      features = '0;
      features[`CONFBIT_MPSIMPLE] = MP_ENABLE;
      features[`CONFBIT_DMA]      = 1'b0;   // no dma engine
   end

   always_comb begin
      ctrl_word = '0;
      ctrl_word[`CTRLBIT_MP_EN] = mp_en;
   end

   // read mux, holes read as 0
   always_comb begin
      case (offset)
         OFS_W'(`REG_TILEID):   conf_rdata = TILE_ID;
         OFS_W'(`REG_NUMTILES): conf_rdata = NUM_TILES;
         OFS_W'(`REG_CONF):     conf_rdata = features;
         OFS_W'(`REG_COREBASE): conf_rdata = CORE_BASE;
         OFS_W'(`REG_CTRL):     conf_rdata = ctrl_word;
         OFS_W'(`REG_SEED):     conf_rdata = seed;   // value before the step
         default:               conf_rdata = '0;
      endcase
   end

   // control register
   // enable sticks at 0 when the unit is not built
   always_ff @(posedge clk) begin
      if (rst) begin
         mp_en <= 1'b0;
      end else if (ctrl_wr) begin
         mp_en <= MP_ENABLE & reg_wdata[`CTRLBIT_MP_EN];
      end
   end

   // seed steps once per accepted read
   always_ff @(posedge clk) begin
      if (rst) begin
         seed <= SEED_INIT;
      end else if (seed_rd) begin
         seed <= seed_next;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/na_flit_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flit fifo, first word fall through
// circular buffer plus head register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module na_flit_fifo #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 32
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         push,
   input  wire logic [WIDTH-1:0]             push_data,
   input  wire logic                         pop,
   output logic      [WIDTH-1:0]             head,    // oldest entry
   output logic                              empty,
   output logic                              full,
   output logic      [$clog2(DEPTH+1)-1:0]   count
);
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW-1:0]    rd_ptr_nxt;
   logic             do_push;
   logic             do_pop;

   // pointer increment with wrap, depth need not be a power of two
   function automatic logic [AW-1:0] wrap_inc(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign empty      = (count == '0);
   assign full       = (count == CW'(DEPTH));
   assign do_push    = push & ~full;    // dropped when full
   assign do_pop     = pop & ~empty;    // ignored when empty
   assign rd_ptr_nxt = wrap_inc(rd_ptr);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wrap_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr_nxt;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // storage and head register
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
      if (do_pop) begin
         if (count == CW'(1)) begin
            head <= push_data;          // last one out, new word (if any) is head
         end else begin
            head <= mem[rd_ptr_nxt];    // next oldest already stored
         end
      end else if (empty && do_push) begin
         head <= push_data;             // first word falls through
      end
   end

endmodule

`default_nettype wire

// ==== rtl/na_mp_simple.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// simple message passing unit
// sw writes to send queue, rx flits queued for sw reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "na_regs.svh"

module na_mp_simple #(
   parameter bit MP_ENABLE  = 1'b1,
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        mp_en,
   input  wire logic                        mp_rd,
   input  wire logic                        mp_wr,
   input  wire logic [na_pkg::OFS_W-1:0]    offset,
   input  wire logic [na_pkg::WORD_W-1:0]   reg_wdata,
   output logic      [na_pkg::WORD_W-1:0]   mp_rdata,
   output logic                             mp_reject,
   output logic      [na_pkg::WORD_W-1:0]   out_flit,
   output logic                             out_valid,
   input  wire logic                        out_ready,
   input  wire logic [na_pkg::WORD_W-1:0]   in_flit,
   input  wire logic                        in_valid,
   output logic                             in_ready
);
   import na_pkg::*;

   generate
      if (MP_ENABLE) begin : gen_mp
         localparam int CW = $clog2(FIFO_DEPTH + 1);

         logic              is_send;
         logic              is_recv;
         logic              is_stat;
         logic              tx_push;
         logic              tx_full;
         logic              tx_empty;
         logic              rx_pop;
         logic              rx_full;
         logic              rx_empty;
         logic [WORD_W-1:0] rx_head;
         logic [CW-1:0]     rx_count;
         logic [WORD_W-1:0] status;

         assign is_send = (offset == OFS_W'(`REG_MP_SEND));
         assign is_recv = (offset == OFS_W'(`REG_MP_RECV));
         assign is_stat = (offset == OFS_W'(`REG_MP_STATUS));

         // one decision per access, push, pop or reject
         assign tx_push   = mp_wr & is_send & mp_en & ~tx_full;
         assign rx_pop    = mp_rd & is_recv & ~rx_empty;
         assign mp_reject = (mp_wr & is_send & (~mp_en | tx_full))
                          | (mp_rd & is_recv & rx_empty)
                          | ((mp_rd | mp_wr) & ~(is_send | is_recv | is_stat));

         na_flit_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(WORD_W)) send_q (
            .clk       (clk),
            .rst       (rst),
            .push      (tx_push),
            .push_data (reg_wdata),
            .pop       (out_valid & out_ready),   // network takes the head
            .head      (out_flit),
            .empty     (tx_empty),
            .full      (tx_full),
            .count     ()
         );

         assign out_valid = ~tx_empty;   // head held until taken

         // inbound, stalls when full or disabled
         assign in_ready = ~rx_full & mp_en;

         na_flit_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(WORD_W)) recv_q (
            .clk       (clk),
            .rst       (rst),
            .push      (in_valid & in_ready),
            .push_data (in_flit),
            .pop       (rx_pop),
            .head      (rx_head),
            .empty     (rx_empty),
            .full      (rx_full),
            .count     (rx_count)
         );

         always_comb begin
            status = '0;
            status[`STATBIT_RX_AVAIL]    = ~rx_empty;
            status[`STATBIT_TX_FULL]     = tx_full;
            status[`STAT_RX_COUNT +: CW] = rx_count;
         end

         // send reads back 0
         assign mp_rdata = is_recv ? rx_head :
                           is_stat ? status  : '0;
      end else begin : gen_none
         // unit not built, every access refused
         assign mp_rdata  = '0;
         assign mp_reject = mp_rd | mp_wr;
         assign out_flit  = '0;
         assign out_valid = 1'b0;
         assign in_ready  = 1'b0;
      end
   endgenerate

endmodule

`default_nettype wire

// ==== rtl/na_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network adapter package
// bus widths, region selects, seed generator constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package na_pkg;

   // wishbone side
   localparam int WORD_W = 32;   // data width
   localparam int ADR_W  = 16;   // byte address width
   localparam int OFS_W  = 10;   // word offset inside a region, adr[11:2]

   // region select in adr[13:12]
   // adr[15:14] nonzero is always unmapped
   localparam logic [1:0] REGION_CONF = 2'd0;   // tile config block
   localparam logic [1:0] REGION_MP   = 2'd1;   // message unit

   // seed generator
   // 32 bit galois lfsr, shifts right
   // when the bit shifted out is 1 the taps are xored in
   localparam logic [WORD_W-1:0] SEED_INIT = 32'h1d2c_3b4a;   // never 0
   localparam logic [WORD_W-1:0] SEED_TAPS = 32'h8020_0003;   // maximal length

endpackage

`default_nettype wire

// ==== rtl/na_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network adapter tile port
// wishbone slave, config block and message unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module na_top #(
   parameter logic [31:0] TILE_ID    = 32'd0,
   parameter logic [31:0] NUM_TILES  = 32'd1,
   parameter logic [31:0] CORE_BASE  = 32'd0,
   parameter bit          MP_ENABLE  = 1'b1,
   parameter int          FIFO_DEPTH = 4
) (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        cyc,
   input  wire logic                        stb,
   input  wire logic                        we,
   input  wire logic [na_pkg::ADR_W-1:0]    adr,
   input  wire logic [na_pkg::WORD_W-1:0]   wdata,
   output logic      [na_pkg::WORD_W-1:0]   rdata,
   output logic                             ack,
   output logic                             err,
   output logic      [na_pkg::WORD_W-1:0]   out_flit,
   output logic                             out_valid,
   input  wire logic                        out_ready,
   input  wire logic [na_pkg::WORD_W-1:0]   in_flit,
   input  wire logic                        in_valid,
   output logic                             in_ready
);
   import na_pkg::*;

   logic              conf_rd;
   logic              conf_wr;
   logic              mp_rd;
   logic              mp_wr;
   logic [OFS_W-1:0]  offset;
   logic [WORD_W-1:0] reg_wdata;
   logic [WORD_W-1:0] conf_rdata;
   logic [WORD_W-1:0] mp_rdata;
   logic              mp_reject;
   logic              mp_en;        // control bit, conf to message unit

   na_wb_slave u_wb (
      .clk        (clk),
      .rst        (rst),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .wdata      (wdata),
      .rdata      (rdata),
      .ack        (ack),
      .err        (err),
      .conf_rd    (conf_rd),
      .conf_wr    (conf_wr),
      .mp_rd      (mp_rd),
      .mp_wr      (mp_wr),
      .offset     (offset),
      .reg_wdata  (reg_wdata),
      .conf_rdata (conf_rdata),
      .mp_rdata   (mp_rdata),
      .mp_reject  (mp_reject)
   );

   na_conf #(
      .TILE_ID   (TILE_ID),
      .NUM_TILES (NUM_TILES),
      .CORE_BASE (CORE_BASE),
      .MP_ENABLE (MP_ENABLE)
   ) u_conf (
      .clk        (clk),
      .rst        (rst),
      .conf_rd    (conf_rd),
      .conf_wr    (conf_wr),
      .offset     (offset),
      .reg_wdata  (reg_wdata),
      .conf_rdata (conf_rdata),
      .mp_en      (mp_en)
   );

   na_mp_simple #(
      .MP_ENABLE  (MP_ENABLE),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_mp (
      .clk        (clk),
      .rst        (rst),
      .mp_en      (mp_en),
      .mp_rd      (mp_rd),
      .mp_wr      (mp_wr),
      .offset     (offset),
      .reg_wdata  (reg_wdata),
      .mp_rdata   (mp_rdata),
      .mp_reject  (mp_reject),
      .out_flit   (out_flit),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .in_flit    (in_flit),
      .in_valid   (in_valid),
      .in_ready   (in_ready)
   );

endmodule

`default_nettype wire

// ==== rtl/na_wb_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic front end
// region decode, one cycle strobes, registered ack/err and read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module na_wb_slave (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        cyc,
   input  wire logic                        stb,
   input  wire logic                        we,
   input  wire logic [na_pkg::ADR_W-1:0]    adr,
   input  wire logic [na_pkg::WORD_W-1:0]   wdata,
   output logic      [na_pkg::WORD_W-1:0]   rdata,
   output logic                             ack,
   output logic                             err,
   output logic                             conf_rd,
   output logic                             conf_wr,
   output logic                             mp_rd,
   output logic                             mp_wr,
   output logic      [na_pkg::OFS_W-1:0]    offset,
   output logic      [na_pkg::WORD_W-1:0]   reg_wdata,
   input  wire logic [na_pkg::WORD_W-1:0]   conf_rdata,
   input  wire logic [na_pkg::WORD_W-1:0]   mp_rdata,
   input  wire logic                        mp_reject
);
   import na_pkg::*;

   logic       accept;     // request taken this cycle
   logic       upper_ok;   // adr[15:14] clear
   logic [1:0] region;
   logic       sel_conf;
   logic       sel_mp;
   logic       ok;         // answer will be ack

   // master holds the request through the ack cycle, so block it then
   assign accept   = cyc & stb & ~(ack | err);
   assign upper_ok = (adr[15:14] == 2'b00);
   assign region   = adr[13:12];
   assign sel_conf = accept & upper_ok & (region == REGION_CONF);
   assign sel_mp   = accept & upper_ok & (region == REGION_MP);

   // strobes to the regions, same cycle as accept
   assign conf_rd   = sel_conf & ~we;
   assign conf_wr   = sel_conf & we;
   assign mp_rd     = sel_mp & ~we;
   assign mp_wr     = sel_mp & we;
   assign offset    = adr[OFS_W+1:2];   // word offset, byte lanes dropped
   assign reg_wdata = wdata;

   // config always acks, message unit may refuse
   assign ok = sel_conf | (sel_mp & ~mp_reject);

   always_ff @(posedge clk) begin
      if (rst) begin
         ack <= 1'b0;
         err <= 1'b0;
      end else begin
         ack <= ok;
         err <= accept & ~ok;   // unmapped or rejected
      end
   end

   // read word, lines up with ack
   always_ff @(posedge clk) begin
      if (accept && !we) begin
         if (sel_conf) begin
            rdata <= conf_rdata;
         end else if (sel_mp) begin
            rdata <= mp_rdata;
         end else begin
            rdata <= '0;   // unmapped
         end
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/na_pkg.sv
rtl/na_wb_slave.sv
rtl/na_conf.sv
rtl/na_flit_fifo.sv
rtl/na_mp_simple.sv
rtl/na_top.sv
dv/na_tb_sva.sv
dv/na_tb.sv
